//--- core_types_pkg.sv
`default_nettype none

package core_types_pkg;

    // ------------------------------------------------------------------
    // sizes

    localparam int PR_COUNT = 64;
    localparam int LOG_PR_COUNT = 6;

    // bank is the low bits of a register index
    localparam int PRF_BANK_COUNT = 4;
    localparam int LOG_PRF_BANK_COUNT = 2;

    localparam int ROB_ENTRIES = 32;
    localparam int LOG_ROB_ENTRIES = 5;

    // ------------------------------------------------------------------
    // immediate opcodes, funct3 in the low bits

    typedef enum logic [3:0] {
        ADDI  = 4'b0000,
        SLLI  = 4'b0001,
        SLTI  = 4'b0010,
        SLTIU = 4'b0011,
        XORI  = 4'b0100,
        SRLI  = 4'b0101,
        SRAI  = 4'b1101,
        ORI   = 4'b0110,
        ANDI  = 4'b0111
    } alu_op_t;

    // ------------------------------------------------------------------
    // payloads

    // issue queue to operand collect
    typedef struct packed {
        alu_op_t                    op;
        logic [11:0]                imm12;
        logic [LOG_PR_COUNT-1:0]    A_PR;
        logic                       A_forward;
        logic [LOG_PR_COUNT-1:0]    dest_PR;
        logic [LOG_ROB_ENTRIES-1:0] ROB_index;
    } issue_t;

    // operand collect to execute
    typedef struct packed {
        alu_op_t                    op;
        logic [31:0]                A;
        logic [11:0]                imm12;
        logic [LOG_PR_COUNT-1:0]    dest_PR;
        logic [LOG_ROB_ENTRIES-1:0] ROB_index;
    } ex_t;

    typedef struct packed {
        logic [31:0]                data;
        logic [LOG_PR_COUNT-1:0]    PR;
        logic [LOG_ROB_ENTRIES-1:0] ROB_index;
    } wb_t;

    typedef struct packed {
        logic                    valid;
        logic [LOG_PR_COUNT-1:0] PR;
        logic [31:0]             data;
    } prf_write_t;

    typedef struct packed {
        logic                    valid;
        logic [LOG_PR_COUNT-1:0] PR;
    } prf_read_req_t;

endpackage

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import core_types_pkg::*; (
    input  alu_op_t     op,
    input  logic [31:0] A,
    input  logic [31:0] B,
    output logic [31:0] out
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // shifts only look at the low five bits of B
    assign shamt = B[4:0];

    assign lt_signed = $signed(A) < $signed(B);
    assign lt_unsigned = A < B;

    always_comb begin
        case (op)
            ADDI: begin
                out = A + B;
            end
            SLLI: begin
                out = A << shamt;
            end
            SLTI: begin
                out = {31'b0, lt_signed};
            end
            SLTIU: begin
                out = {31'b0, lt_unsigned};
            end
            XORI: begin
                out = A ^ B;
            end
            SRLI: begin
                out = A >> shamt;
            end
            SRAI: begin
                // arithmetic, sign bit fills from the top
                out = $unsigned($signed(A) >>> shamt);
            end
            ORI: begin
                out = A | B;
            end
            ANDI: begin
                out = A & B;
            end
            default: begin
                out = 32'h0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- operand_collect_stage.sv
`timescale 1ns/1ps
`default_nettype none

module operand_collect_stage import core_types_pkg::*; (
    input  logic                                    CLK,
    input  logic                                    nRST,

    // issue queue side
    input  logic                                    issue_valid,
    input  issue_t                                  issue,
    output logic                                    issue_ready,

    // register file read
    output prf_read_req_t                           A_read_req,
    input  logic                                    A_reg_read_ack,
    input  logic                                    A_reg_read_port,
    input  logic [PRF_BANK_COUNT-1:0][1:0][31:0]    reg_read_data_by_bank_by_port,
    input  logic [PRF_BANK_COUNT-1:0][31:0]         forward_data_by_bank,

    // execute side
    input  logic                                    ex_stall,
    output logic                                    ex_valid,
    output ex_t                                     ex_payload
);

    // ------------------------------------------------------------------
    // held op

    logic       valid_oc;
    logic       saved_oc;
    logic       forward_oc;
    issue_t     held_op;
    logic [31:0] saved_a;

    logic [LOG_PRF_BANK_COUNT-1:0] a_bank;
    logic [31:0] a_value;
    logic        a_present;
    logic        launch;

    assign a_bank = held_op.A_PR[LOG_PRF_BANK_COUNT-1:0];

    // ------------------------------------------------------------------
    // operand select and launch

    // only ask for a port when nothing else will supply A
    assign A_read_req.valid = valid_oc & ~saved_oc & ~forward_oc;
    assign A_read_req.PR = held_op.A_PR;

    assign a_present = saved_oc | forward_oc | A_reg_read_ack;
    assign launch = valid_oc & a_present & ~ex_stall;

    assign issue_ready = ~valid_oc | launch;

    always_comb begin
        // saved copy first, then forward, then the read port
        if (saved_oc) begin
            a_value = saved_a;
        end else if (forward_oc) begin
            a_value = forward_data_by_bank[a_bank];
        end else begin
            a_value = reg_read_data_by_bank_by_port[a_bank][A_reg_read_port];
        end
    end

    assign ex_valid = launch;
    assign ex_payload.op = held_op.op;
    assign ex_payload.A = a_value;
    assign ex_payload.imm12 = held_op.imm12;
    assign ex_payload.dest_PR = held_op.dest_PR;
    assign ex_payload.ROB_index = held_op.ROB_index;

    // ------------------------------------------------------------------
    // state

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_oc <= 1'b0;
            saved_oc <= 1'b0;
            forward_oc <= 1'b0;
        end else if (issue_ready) begin
            valid_oc <= issue_valid;
            saved_oc <= 1'b0;
            forward_oc <= issue_valid & issue.A_forward;
        end else begin
            // waiting or stalled, remember whatever arrived
            saved_oc <= saved_oc | forward_oc | A_reg_read_ack;
            forward_oc <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_ready) begin
            held_op <= issue;
        end
    end

    // capture A while the op sits in OC
    always_ff @(posedge CLK) begin
        if (!issue_ready) begin
            saved_a <= a_value;
        end
    end

    // ------------------------------------------------------------------
    // checks

    // register file must not grant a port nobody asked for
    ack_needs_req: assert property (
        @(posedge CLK) disable iff (!nRST)
        A_reg_read_ack |-> A_read_req.valid
    );

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import core_types_pkg::*; (
    input  logic CLK,
    input  logic nRST,

    // from operand collect
    input  logic ex_valid,
    input  ex_t  ex_payload,
    output logic ex_stall,

    // writeback
    output logic WB_valid,
    output wb_t  WB,
    input  logic WB_ready
);

    logic        valid_ex;
    ex_t         ex_reg;
    logic [31:0] b_ex;
    logic [31:0] alu_out;
    logic        wb_stall;

    // ------------------------------------------------------------------
    // stall control

    assign wb_stall = WB_valid & ~WB_ready;
    assign ex_stall = valid_ex & wb_stall;

    // ------------------------------------------------------------------
    // EX register

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_ex <= 1'b0;
        end else if (!ex_stall) begin
            valid_ex <= ex_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!ex_stall) begin
            ex_reg <= ex_payload;
        end
    end

    assign b_ex = {{20{ex_reg.imm12[11]}}, ex_reg.imm12};

    alu u_alu (
        .op  (ex_reg.op),
        .A   (ex_reg.A),
        .B   (b_ex),
        .out (alu_out)
    );

    // ------------------------------------------------------------------
    // WB register

    // holds its contents while the register file refuses the write
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            WB_valid <= 1'b0;
            WB <= '0;
        end else if (!wb_stall) begin
            WB_valid <= valid_ex;
            WB.data <= alu_out;
            WB.PR <= ex_reg.dest_PR;
            WB.ROB_index <= ex_reg.ROB_index;
        end
    end

    // held writeback must not change until the register file takes it
    wb_hold_stable: assert property (
        @(posedge CLK) disable iff (!nRST)
        (WB_valid && !WB_ready) |=> (WB_valid && $stable(WB))
    );

endmodule

`default_nettype wire

//--- phys_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module phys_reg_file import core_types_pkg::*; (
    input  logic                                    CLK,
    input  logic                                    nRST,

    // external requesters
    input  prf_write_t                              ext_write,
    input  prf_read_req_t [1:0]                     ext_read,
    output logic [1:0][31:0]                        ext_read_data,

    // operand collect read
    input  prf_read_req_t                           A_read_req,
    output logic                                    A_reg_read_ack,
    output logic                                    A_reg_read_port,
    output logic [PRF_BANK_COUNT-1:0][1:0][31:0]    reg_read_data_by_bank_by_port,
    output logic [PRF_BANK_COUNT-1:0][31:0]         forward_data_by_bank,

    // writeback from execute
    input  logic                                    WB_valid,
    input  wb_t                                     WB,
    output logic                                    WB_ready
);

    logic [31:0] regs [PR_COUNT];

    logic [LOG_PRF_BANK_COUNT-1:0] r0_bank;
    logic [LOG_PRF_BANK_COUNT-1:0] r1_bank;
    logic [LOG_PRF_BANK_COUNT-1:0] a_bank;
    logic [LOG_PRF_BANK_COUNT-1:0] ext_bank;
    logic [LOG_PRF_BANK_COUNT-1:0] wb_bank;
    logic                          r1_port;

    logic [PRF_BANK_COUNT-1:0][1:0]                    port_busy;
    logic [PRF_BANK_COUNT-1:0][1:0][LOG_PR_COUNT-1:0]  port_pr;
    prf_write_t [PRF_BANK_COUNT-1:0]                   bank_write;
    logic                                              wb_write;

    assign r0_bank = ext_read[0].PR[LOG_PRF_BANK_COUNT-1:0];
    assign r1_bank = ext_read[1].PR[LOG_PRF_BANK_COUNT-1:0];
    assign a_bank = A_read_req.PR[LOG_PRF_BANK_COUNT-1:0];
    assign ext_bank = ext_write.PR[LOG_PRF_BANK_COUNT-1:0];
    assign wb_bank = WB.PR[LOG_PRF_BANK_COUNT-1:0];

    // ------------------------------------------------------------------
    // read port allocation

    always_comb begin
        port_busy = '0;
        port_pr = '0;
        r1_port = 1'b0;
        A_reg_read_ack = 1'b0;
        A_reg_read_port = 1'b0;

        // ext 0 always owns port 0
        if (ext_read[0].valid) begin
            port_busy[r0_bank][0] = 1'b1;
            port_pr[r0_bank][0] = ext_read[0].PR;
        end

        // ext 1 takes the lowest port left
        if (ext_read[1].valid) begin
            r1_port = port_busy[r1_bank][0];
            port_busy[r1_bank][r1_port] = 1'b1;
            port_pr[r1_bank][r1_port] = ext_read[1].PR;
        end

        // OC gets leftovers only
        if (A_read_req.valid && !(&port_busy[a_bank])) begin
            A_reg_read_ack = 1'b1;
            A_reg_read_port = port_busy[a_bank][0];
            port_pr[a_bank][A_reg_read_port] = A_read_req.PR;
        end
    end

    always_comb begin
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            for (int p = 0; p < 2; p++) begin
                reg_read_data_by_bank_by_port[b][p] = regs[port_pr[b][p]];
            end
        end
    end

    assign ext_read_data[0] = reg_read_data_by_bank_by_port[r0_bank][0];
    assign ext_read_data[1] = reg_read_data_by_bank_by_port[r1_bank][r1_port];

    // ------------------------------------------------------------------
    // write arbitration, external write wins its bank

    assign WB_ready = ~(ext_write.valid & (ext_bank == wb_bank));
    assign wb_write = WB_valid & WB_ready;

    always_comb begin
        bank_write = '0;
        if (wb_write) begin
            bank_write[wb_bank].valid = 1'b1;
            bank_write[wb_bank].PR = WB.PR;
            bank_write[wb_bank].data = WB.data;
        end
        if (ext_write.valid) begin
            bank_write[ext_bank] = ext_write;
        end
    end

    always_comb begin
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            forward_data_by_bank[b] = bank_write[b].data;
        end
    end

    // writes land at the edge, reads see them next cycle
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < PR_COUNT; i++) begin
                regs[i] <= 32'h0;
            end
        end else begin
            for (int b = 0; b < PRF_BANK_COUNT; b++) begin
                if (bank_write[b].valid) begin
                    regs[bank_write[b].PR] <= bank_write[b].data;
                end
            end
        end
    end

    // a bank hit by both writes takes only the external one
    one_write_per_bank: assert property (
        @(posedge CLK) disable iff (!nRST)
        (WB_valid && ext_write.valid && ext_bank == wb_bank) |->
            (!WB_ready && forward_data_by_bank[ext_bank] == ext_write.data)
    );

endmodule

`default_nettype wire

//--- alu_imm_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module alu_imm_subsystem import core_types_pkg::*; (
    input  logic                CLK,
    input  logic                nRST,

    // issue
    input  logic                issue_valid,
    input  issue_t              issue,
    output logic                issue_ready,

    // other pipelines
    input  prf_write_t          ext_write,
    input  prf_read_req_t [1:0] ext_read,
    output logic [1:0][31:0]    ext_read_data,

    // writeback, visible for checking
    output logic                WB_valid,
    output wb_t                 WB,
    output logic                WB_ready
);

    // ------------------------------------------------------------------
    // OC to register file and EX

    prf_read_req_t                          A_read_req;
    logic                                   A_reg_read_ack;
    logic                                   A_reg_read_port;
    logic [PRF_BANK_COUNT-1:0][1:0][31:0]   reg_read_data_by_bank_by_port;
    logic [PRF_BANK_COUNT-1:0][31:0]        forward_data_by_bank;
    logic                                   ex_stall;
    logic                                   ex_valid;
    ex_t                                    ex_payload;

    operand_collect_stage u_oc (
        .CLK                           (CLK),
        .nRST                          (nRST),
        .issue_valid                   (issue_valid),
        .issue                         (issue),
        .issue_ready                   (issue_ready),
        .A_read_req                    (A_read_req),
        .A_reg_read_ack                (A_reg_read_ack),
        .A_reg_read_port               (A_reg_read_port),
        .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
        .forward_data_by_bank          (forward_data_by_bank),
        .ex_stall                      (ex_stall),
        .ex_valid                      (ex_valid),
        .ex_payload                    (ex_payload)
    );

    execute_stage u_ex (
        .CLK        (CLK),
        .nRST       (nRST),
        .ex_valid   (ex_valid),
        .ex_payload (ex_payload),
        .ex_stall   (ex_stall),
        .WB_valid   (WB_valid),
        .WB         (WB),
        .WB_ready   (WB_ready)
    );

    phys_reg_file u_prf (
        .CLK                           (CLK),
        .nRST                          (nRST),
        .ext_write                     (ext_write),
        .ext_read                      (ext_read),
        .ext_read_data                 (ext_read_data),
        .A_read_req                    (A_read_req),
        .A_reg_read_ack                (A_reg_read_ack),
        .A_reg_read_port               (A_reg_read_port),
        .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
        .forward_data_by_bank          (forward_data_by_bank),
        .WB_valid                      (WB_valid),
        .WB                            (WB),
        .WB_ready                      (WB_ready)
    );

endmodule

`default_nettype wire

//--- tb_alu_imm_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_alu_imm_subsystem import core_types_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_OPS = 300;
    localparam int WATCHDOG_CYCLES = 400 * 30;

    typedef struct packed {
        alu_op_t op;
        wb_t     wb;
    } expect_t;

    logic                CLK = 1'b0;
    logic                nRST;
    logic                issue_valid;
    issue_t              issue;
    logic                issue_ready;
    prf_write_t          ext_write;
    prf_read_req_t [1:0] ext_read;
    logic [1:0][31:0]    ext_read_data;
    logic                WB_valid;
    wb_t                 WB;
    logic                WB_ready;

    // reference state
    logic [31:0]       model_regs [PR_COUNT];
    expect_t           exp_q [$];
    logic [31:0]       rng;
    int                checks;
    int                errors;
    int                accepted;
    int                fwd_count;
    int                stall_count;
    int                op_seen [16];

    // per-cycle bookkeeping between drive and observe
    logic                    accepted_last;
    logic                    fwd_due;
    logic [LOG_PR_COUNT-1:0] fwd_pr;
    logic [31:0]             fwd_data;
    logic [31:0]             pend_fwd_value;
    logic                    stall_prev;
    wb_t                     wb_prev;

    alu_imm_subsystem u_dut (
        .CLK           (CLK),
        .nRST          (nRST),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .issue_ready   (issue_ready),
        .ext_write     (ext_write),
        .ext_read      (ext_read),
        .ext_read_data (ext_read_data),
        .WB_valid      (WB_valid),
        .WB            (WB),
        .WB_ready      (WB_ready)
    );

    always #(CLK_PERIOD/2) CLK = ~CLK;

    // ----------------------------------------------------------------------
    // helpers

    function automatic logic [31:0] rand_word();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic alu_op_t pick_op(input logic [3:0] sel);
        case (sel)
            4'd0: return ADDI;
            4'd1: return SLLI;
            4'd2: return SLTI;
            4'd3: return SLTIU;
            4'd4: return XORI;
            4'd5: return SRLI;
            4'd6: return SRAI;
            4'd7: return ORI;
            default: return ANDI;
        endcase
    endfunction

    // immediate ALU rules, B is imm12 sign extended
    function automatic logic [31:0] model_alu(input alu_op_t op, input logic [31:0] a,
                                              input logic [11:0] imm);
        logic [31:0] b;
        logic [4:0]  sh;
        b = {{20{imm[11]}}, imm};
        sh = b[4:0];
        case (op)
            ADDI:  return a + b;
            SLLI:  return a << sh;
            // signs differ means the negative one is smaller
            SLTI:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            SLTIU: return {31'b0, a < b};
            XORI:  return a ^ b;
            SRLI:  return a >> sh;
            SRAI:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            ORI:   return a | b;
            ANDI:  return a & b;
            default: return 32'h0;
        endcase
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] want,
                              input string what);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("FAIL %0t: %s got %h, expected %h", $time, what, got, want);
        end
    endtask

    // ----------------------------------------------------------------------
    // stimulus, called right after a falling edge

    task automatic drive_inputs(input logic allow_issue);
        logic [31:0] r;
        if (accepted_last) begin
            issue_valid = 1'b0;
        end
        if (allow_issue && !issue_valid && accepted < NUM_OPS) begin
            r = rand_word();
            if (r[1:0] != 2'b00) begin
                issue_valid = 1'b1;
                issue.op = pick_op(4'(rand_word() % 32'd9));
                issue.imm12 = r[13:2];
                issue.A_PR = {1'b0, r[18:14]};
                issue.A_forward = (r[21:19] == 3'b000);
                issue.dest_PR = {1'b1, r[26:22]};
                issue.ROB_index = 5'(accepted);
                pend_fwd_value = rand_word();
            end
        end

        // forward write owns the port in the cycle after acceptance
        r = rand_word();
        if (fwd_due) begin
            ext_write.valid = 1'b1;
            ext_write.PR = fwd_pr;
            ext_write.data = fwd_data;
        end else if (r[1:0] == 2'b00) begin
            ext_write.valid = 1'b1;
            ext_write.PR = {1'b1, r[6:2]};
            ext_write.data = rand_word();
        end else begin
            ext_write = '0;
        end

        r = rand_word();
        ext_read[0].valid = r[0];
        ext_read[0].PR = r[6:1];
        ext_read[1].valid = r[7];
        ext_read[1].PR = r[13:8];
    endtask

    // ----------------------------------------------------------------------
    // sample just before the rising edge, then update the model

    task automatic observe_cycle();
        expect_t e;
        logic    bank_hit;
        #(CLK_PERIOD/2 - 5);

        if (stall_prev) begin
            checks++;
            assert (WB_valid === 1'b1 && WB === wb_prev) else begin
                errors++;
                $display("FAIL %0t: held writeback changed while stalled", $time);
            end
        end
        if (WB_valid) begin
            bank_hit = ext_write.valid && (ext_write.PR[1:0] == WB.PR[1:0]);
            check_word({31'b0, WB_ready}, {31'b0, !bank_hit}, "WB_ready");
        end
        stall_prev = WB_valid && !WB_ready;
        wb_prev = WB;
        if (stall_prev) begin
            stall_count++;
        end

        for (int i = 0; i < 2; i++) begin
            if (ext_read[i].valid) begin
                check_word(ext_read_data[i], model_regs[ext_read[i].PR], "ext read data");
            end
        end

        if (WB_valid && WB_ready) begin
            checks++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("ERROR: a writeback left at %0t with no op outstanding", $time);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_word(WB.data, e.wb.data, "writeback data");
                check_word({26'b0, WB.PR}, {26'b0, e.wb.PR}, "writeback PR");
                check_word({27'b0, WB.ROB_index}, {27'b0, e.wb.ROB_index}, "ROB index");
                op_seen[e.op]++;
                model_regs[e.wb.PR] = e.wb.data;
            end
        end
        if (ext_write.valid) begin
            model_regs[ext_write.PR] = ext_write.data;
        end

        // A comes from the model after this edge's writes land
        accepted_last = issue_valid && issue_ready;
        fwd_due = accepted_last && issue.A_forward;
        if (accepted_last) begin
            e.op = issue.op;
            e.wb.PR = issue.dest_PR;
            e.wb.ROB_index = issue.ROB_index;
            e.wb.data = model_alu(issue.op,
                                  issue.A_forward ? pend_fwd_value : model_regs[issue.A_PR],
                                  issue.imm12);
            exp_q.push_back(e);
            accepted++;
            if (issue.A_forward) begin
                fwd_count++;
                fwd_pr = issue.A_PR;
                fwd_data = pend_fwd_value;
            end
        end
        @(negedge CLK);
    endtask

    // ----------------------------------------------------------------------
    // main sequence

    initial begin
        nRST = 1'b0;
        issue_valid = 1'b0;
        issue = '0;
        ext_write = '0;
        ext_read = '0;
        rng = 32'd19;
        checks = 0;
        errors = 0;
        accepted = 0;
        fwd_count = 0;
        stall_count = 0;
        accepted_last = 1'b0;
        fwd_due = 1'b0;
        fwd_pr = '0;
        fwd_data = '0;
        pend_fwd_value = '0;
        stall_prev = 1'b0;
        wb_prev = '0;
        for (int i = 0; i < 16; i++) begin
            op_seen[i] = 0;
        end
        for (int i = 0; i < PR_COUNT; i++) begin
            model_regs[i] = 32'h0;
        end

        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        #(CLK_PERIOD/4);
        check_word({31'b0, issue_ready}, 32'd1, "issue_ready after reset");
        check_word({31'b0, WB_valid}, 32'd0, "WB_valid after reset");
        @(negedge CLK);

        // load the source registers
        for (int i = 0; i < 32; i++) begin
            ext_write.valid = 1'b1;
            ext_write.PR = 6'(i);
            ext_write.data = rand_word();
            observe_cycle();
        end
        ext_write = '0;

        while (accepted < NUM_OPS) begin
            drive_inputs(1'b1);
            observe_cycle();
        end
        while (exp_q.size() != 0) begin
            drive_inputs(1'b0);
            observe_cycle();
        end
        // nothing more may come out
        repeat (20) begin
            drive_inputs(1'b0);
            observe_cycle();
        end

        for (int k = 0; k < 9; k++) begin
            alu_op_t cov_op;
            cov_op = pick_op(4'(k));
            checks++;
            assert (op_seen[cov_op] > 0) else begin
                errors++;
                $display("ERROR: opcode %s never completed", cov_op.name());
            end
        end
        checks++;
        assert (fwd_count > 0 && stall_count > 0) else begin
            errors++;
            $display("ERROR: no forwarded op or no writeback stall was seen");
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
core_types_pkg.sv
alu.sv
operand_collect_stage.sv
execute_stage.sv
phys_reg_file.sv
alu_imm_subsystem.sv
tb_alu_imm_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, pass only if the log holds the pass message

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module tb_alu_imm_subsystem -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee sim.log \
    || echo "build or simulation did not complete"

grep -q "^SIMULATION PASSED$" sim.log 2>/dev/null \
    && echo "run_sim: passed" \
    || { echo "run_sim: failed, see sim.log"; exit 1; }
